// ==== build.f ====
hw/msg_loopback_pkg.sv
hw/msg_handshake_if.sv
hw/msg_fifo.sv
hw/msg_decode.sv
hw/msg_execute.sv
hw/msg_result.sv
hw/msg_loopback_top.sv
dv/tb_msg_loopback.sv

// ==== dv/tb_msg_loopback.sv ====
`timescale 1ns/1ps

module tb_msg_loopback;
  import msg_loopback_pkg::*;

  localparam int cycle_limit = 3000;  // 64 words at 40 cycles each, plus reset

  logic       reset;     // clock
  logic       bus_clk;   // async reset, active high
  host_word_t write_data;
  logic       write_en;
  logic       write_full;
  resp_word_t read_data;
  logic       read_en;
  logic       read_empty;
  logic [7:0] led;

  integer      seed;
  int          cycles;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_bad;
  bit          read_on;    // checker may pop responses
  bit          gap_mode;   // random pauses between reads
  bit          full_seen;
  resp_word_t  expect_q[$];
  logic [23:0] model_acc;
  logic [23:0] model_msgs;
  logic [23:0] model_errs;
  logic [7:0]  model_seq;

  msg_loopback_top dut0 (
    .reset      (reset),
    .bus_clk    (bus_clk),
    .write_data (write_data),
    .write_en   (write_en),
    .write_full (write_full),
    .read_data  (read_data),
    .read_en    (read_en),
    .read_empty (read_empty),
    .led        (led)
  );

  initial begin
    reset = 1'b0;
    forever #2 reset = ~reset;
  end

  // expected reply for one accepted word, advances the model
  function automatic bit ref_response(input logic [7:0] op, input logic [23:0] operand,
                                      output resp_word_t rsp);
    bit has_rsp;
    has_rsp    = 1'b1;
    model_msgs = model_msgs + 24'd1;  // this word counts too
    rsp.seq    = model_seq;
    model_seq  = model_seq + 8'd1;
    case (op)
      OP_ECHO:  rsp.value = operand;
      OP_ADD: begin
        model_acc = model_acc + operand;  // wraps at 2^24
        rsp.value = model_acc;
      end
      OP_CLEAR: begin
        model_acc = '0;
        rsp.value = '0;
        has_rsp   = 1'b0;  // silent
      end
      OP_COUNT: rsp.value = model_msgs;
      default: begin
        model_errs = model_errs + 24'd1;
        rsp.value  = ERR_VALUE;
      end
    endcase
    return has_rsp;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got == want) else begin
      $display("Fail %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  // one host write, never while the command fifo is full
  task automatic send_word(input logic [7:0] op, input logic [23:0] operand);
    resp_word_t exp_rsp;
    @(posedge reset);
    while (write_full) begin
      full_seen = 1'b1;
      read_on   = 1'b1;  // stalled, so let responses drain
      @(posedge reset);
    end
    write_data <= {op, operand};
    write_en   <= 1'b1;
    @(posedge reset);
    write_en   <= 1'b0;
    if (ref_response(op, operand, exp_rsp)) begin
      expect_q.push_back(exp_rsp);
    end
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0) begin
      @(posedge reset);
    end
  endtask

  task automatic end_test(input string name, input int errs_start);
    tests_run++;
    if (errors == errs_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errs_start);
    end
  endtask

  // response checker, one pop every other cycle at most
  always @(posedge reset) begin
    resp_word_t exp_rsp;
    int         gap_val;
    bit         pause;
    if (bus_clk) begin
      read_en <= 1'b0;
    end else begin
      if (read_en) begin  // word popped at this edge
        assert (expect_q.size() != 0) else begin
          $display("response with seq %h arrived but none was expected", read_data.seq);
          errors++;
        end
        if (expect_q.size() != 0) begin
          exp_rsp = expect_q.pop_front();
          check_field("read_data.seq", 32'(read_data.seq), 32'(exp_rsp.seq));
          check_field("read_data.value", 32'(read_data.value), 32'(exp_rsp.value));
        end
      end
      pause = 1'b0;
      if (gap_mode) begin
        gap_val = $random(seed);
        pause   = gap_val[0];
      end
      if (!read_en && !read_empty && read_on && !pause) begin
        read_en <= 1'b1;
      end else begin
        read_en <= 1'b0;
      end
    end
  end

  always @(posedge reset) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d responses never arrived", cycles,
               expect_q.size());
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [23:0] operands [24];
    int          i;
    int          errs_start;
    seed       = 97;
    cycles     = 0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    tests_bad  = 0;
    read_on    = 1'b1;
    gap_mode   = 1'b0;
    full_seen  = 1'b0;
    model_acc  = '0;
    model_msgs = '0;
    model_errs = '0;
    model_seq  = '0;
    bus_clk    = 1'b1;
    write_en   = 1'b0;
    write_data = '0;
    read_en    = 1'b0;
    repeat (16) @(posedge reset);
    bus_clk <= 1'b0;
    @(posedge reset);
    check_field("led", 32'(led), 32'h0);
    check_field("read_empty", 32'(read_empty), 32'h1);
    check_field("write_full", 32'(write_full), 32'h0);

    errs_start = errors;
    for (i = 0; i < 10; i++) begin
      send_word(OP_ECHO, 24'($random(seed)));
    end
    wait_drain();
    end_test("echo", errs_start);

    errs_start = errors;
    send_word(OP_CLEAR, 24'd0);
    for (i = 0; i < 4; i++) begin
      send_word(OP_ADD, 24'($random(seed)));
    end
    send_word(OP_ADD, 24'hff_ff00);
    send_word(OP_ADD, 24'hff_ff00);  // the two together pass 2^24
    send_word(OP_CLEAR, 24'd0);
    send_word(OP_ADD, 24'h00_0123);  // starts from zero again
    wait_drain();
    end_test("add and clear", errs_start);

    errs_start = errors;
    send_word(OP_COUNT, 24'd0);
    for (i = 0; i < 3; i++) begin
      send_word(OP_ECHO, 24'($random(seed)));
    end
    send_word(OP_COUNT, 24'd0);
    wait_drain();
    check_field("led[7:4]", 32'(led[7:4]), 32'(model_msgs[3:0]));
    end_test("count and led", errs_start);

    errs_start = errors;
    send_word(8'h00, 24'h00_0001);
    send_word(8'ha5, 24'($random(seed)));
    send_word(8'hff, 24'h12_3456);
    wait_drain();
    check_field("led[3:0]", 32'(led[3:0]), 32'(model_errs[3:0]));
    end_test("unknown opcode", errs_start);

    errs_start = errors;
    for (i = 0; i < 24; i++) begin
      operands[i] = 24'($random(seed));
    end
    read_on   = 1'b0;  // hold the host side until write_full rises
    gap_mode  = 1'b1;
    full_seen = 1'b0;
    for (i = 0; i < 24; i++) begin
      send_word(OP_ECHO, operands[i]);
    end
    read_on = 1'b1;
    wait_drain();
    assert (full_seen) else begin
      $display("write_full never rose while responses were held back");
      errors++;
    end
    end_test("back-pressure", errs_start);

    $display("%0d tests run, %0d with errors, %0d checks, %0d errors", tests_run,
             tests_bad, checks, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== hw/msg_decode.sv ====
`timescale 1ns/1ps

module msg_decode (
  input  logic                         reset,       // clock
  input  logic                         bus_clk,     // async reset, active high
  input  logic                         fifo_empty,
  input  msg_loopback_pkg::host_word_t fifo_item,
  output logic                         fifo_pop,
  cmd_if.producer                      cmd
);
  import msg_loopback_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,     // waiting for a command word
    S_HOLD,     // req high, waiting for ack
    S_RELEASE   // req dropped, waiting for ack low
  } state_t;

  state_t     state;
  logic [7:0] seq_cnt;  // next sequence number
  logic       req_q;
  cmd_t       cmd_q;

  // pop in the same cycle the word is seen
  assign fifo_pop = (state == S_IDLE) && !fifo_empty;
  assign cmd.req  = req_q;
  assign cmd.cmd  = cmd_q;

  always_ff @(posedge reset) begin
    if (fifo_pop) begin
      cmd_q.opcode  <= fifo_item.opcode;
      cmd_q.operand <= fifo_item.operand;
      cmd_q.seq     <= seq_cnt;
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      state   <= S_IDLE;
      seq_cnt <= '0;
      req_q   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (!fifo_empty) begin
            req_q   <= 1'b1;
            seq_cnt <= seq_cnt + 8'd1;  // wraps at 256
            state   <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (cmd.ack) begin
            req_q <= 1'b0;
            state <= S_RELEASE;
          end
        end
        S_RELEASE: begin
          if (!cmd.ack) begin
            state <= S_IDLE;  // handshake closed
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // execute samples cmd over several cycles before it acks
  a_cmd_stable: assert property (
    @(posedge reset) disable iff (bus_clk)
    (cmd.req && !cmd.ack) |=> $stable(cmd.cmd)
  ) else $error("msg_decode: cmd changed while req pending");

endmodule

// ==== hw/msg_execute.sv ====
`timescale 1ns/1ps

module msg_execute (
  input  logic       reset,      // clock
  input  logic       bus_clk,    // async reset, active high
  cmd_if.consumer    cmd,
  rsp_if.producer    rsp,
  output logic [3:0] msg_count,
  output logic [3:0] err_count
);
  import msg_loopback_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,   // waiting for cmd req
    S_RSP,    // rsp req high, waiting for result
    S_DONE    // cmd ack high, closing both links
  } state_t;

  state_t      state;
  logic [23:0] acc;
  logic [23:0] msg_cnt;      // accepted words
  logic [23:0] err_cnt;      // unknown opcodes
  logic        cmd_ack_q;
  logic        rsp_req_q;
  logic [7:0]  rsp_seq_q;
  logic [23:0] rsp_value_q;
  logic [23:0] value_d;      // reply for the pending command
  logic        known;

  assign cmd.ack   = cmd_ack_q;
  assign rsp.req   = rsp_req_q;
  assign rsp.seq   = rsp_seq_q;
  assign rsp.value = rsp_value_q;
  assign msg_count = msg_cnt[3:0];
  assign err_count = err_cnt[3:0];

  always_comb begin
    value_d = cmd.cmd.operand;
    known   = 1'b1;
    case (cmd.cmd.opcode)
      OP_ECHO:  value_d = cmd.cmd.operand;
      OP_ADD:   value_d = acc + cmd.cmd.operand;  // mod 2^24
      OP_COUNT: value_d = msg_cnt + 24'd1;        // includes this word
      OP_CLEAR: value_d = '0;                      // no reply sent
      default: begin
        value_d = ERR_VALUE;
        known   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge reset) begin
    if (state == S_IDLE && cmd.req) begin
      rsp_seq_q   <= cmd.cmd.seq;
      rsp_value_q <= value_d;
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      state     <= S_IDLE;
      acc       <= '0;
      msg_cnt   <= '0;
      err_cnt   <= '0;
      cmd_ack_q <= 1'b0;
      rsp_req_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd.req && cmd.cmd.opcode == OP_CLEAR) begin
            acc       <= '0;
            msg_cnt   <= msg_cnt + 24'd1;
            cmd_ack_q <= 1'b1;
            state     <= S_DONE;
          end else if (cmd.req) begin
            rsp_req_q <= 1'b1;  // payload latched this edge
            state     <= S_RSP;
          end
        end
        S_RSP: begin
          if (rsp.ack) begin
            rsp_req_q <= 1'b0;
            cmd_ack_q <= 1'b1;  // counts move with ack
            msg_cnt   <= msg_cnt + 24'd1;
            if (!known) err_cnt <= err_cnt + 24'd1;
            if (cmd.cmd.opcode == OP_ADD) acc <= rsp_value_q;
            state     <= S_DONE;
          end
        end
        S_DONE: begin
          if (!cmd.req && !rsp.ack) begin
            cmd_ack_q <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // result must have closed the previous handshake
  a_rsp_req_rise: assert property (
    @(posedge reset) disable iff (bus_clk) $rose(rsp.req) |-> !rsp.ack
  ) else $error("msg_execute: rsp req rose with ack high");

endmodule

// ==== hw/msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo #(
  parameter type item_t = logic [31:0],
  parameter int  depth  = 8
) (
  input  logic  reset,      // clock
  input  logic  bus_clk,    // async reset, active high
  input  logic  push,
  input  item_t push_item,
  output logic  full,
  input  logic  pop,
  output item_t pop_item,   // show-ahead, valid while !empty
  output logic  empty
);

  item_t                      mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;  // occupancy
  logic                       do_push;
  logic                       do_pop;

  assign do_push  = push && !full;  // writes while full are dropped
  assign do_pop   = pop && !empty;
  assign full     = (count == depth);
  assign empty    = (count == 0);
  assign pop_item = mem[rd_ptr];

  always_ff @(posedge reset) begin
    if (do_push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // the surrounding logic must respect the flags
  a_no_push_full: assert property (
    @(posedge reset) disable iff (bus_clk) !(push && full)
  ) else $error("msg_fifo: push while full");

  a_no_pop_empty: assert property (
    @(posedge reset) disable iff (bus_clk) !(pop && empty)
  ) else $error("msg_fifo: pop while empty");

endmodule

// ==== hw/msg_handshake_if.sv ====
`timescale 1ns/1ps

// four-phase req/ack link, decode to execute
interface cmd_if;
  import msg_loopback_pkg::*;

  logic req;
  logic ack;
  cmd_t cmd;  // held while req is high

  modport producer (output req, output cmd, input ack);
  modport consumer (input req, input cmd, output ack);

endinterface

// four-phase req/ack link, execute to result
interface rsp_if;

  logic        req;
  logic        ack;
  logic [7:0]  seq;
  logic [23:0] value;

  modport producer (output req, output seq, output value, input ack);
  modport consumer (input req, input seq, input value, output ack);

endinterface

// ==== hw/msg_loopback_pkg.sv ====
package msg_loopback_pkg;

  typedef enum logic [7:0] {
    OP_ECHO  = 8'd1,  // return operand
    OP_ADD   = 8'd2,  // accumulate operand
    OP_CLEAR = 8'd3,  // zero accumulator, silent
    OP_COUNT = 8'd4   // return accepted word count
  } opcode_e;

  // host command word as written into the command fifo
  typedef struct packed {
    logic [7:0]  opcode;   // raw byte, may hold unknown codes
    logic [23:0] operand;
  } host_word_t;

  // response word as read back by the host
  typedef struct packed {
    logic [7:0]  seq;
    logic [23:0] value;
  } resp_word_t;

  // decoded command handed from decode to execute
  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] operand;
    logic [7:0]  seq;
  } cmd_t;

  localparam int CMD_DEPTH = 8;  // command fifo entries
  localparam int RSP_DEPTH = 8;  // response fifo entries

  localparam logic [23:0] ERR_VALUE = 24'hff_ffff;  // unknown opcode reply

endpackage

// ==== hw/msg_loopback_top.sv ====
`timescale 1ns/1ps

module msg_loopback_top (
  input  logic        reset,        // clock
  input  logic        bus_clk,      // async reset, active high
  input  logic [31:0] write_data,
  input  logic        write_en,
  output logic        write_full,
  output logic [31:0] read_data,
  input  logic        read_en,
  output logic        read_empty,
  output logic [7:0]  led
);
  import msg_loopback_pkg::*;

  host_word_t cmd_item;
  logic       cmd_empty;
  logic       cmd_pop;
  resp_word_t rsp_item;
  logic       rsp_push;
  logic       rsp_full;
  logic [3:0] msg_count;
  logic [3:0] err_count;

  cmd_if cmd_if0 ();
  rsp_if rsp_if0 ();

  assign led = {msg_count, err_count};  // messages high, errors low

  msg_fifo #(
    .item_t (host_word_t),
    .depth  (CMD_DEPTH)
  ) cmd_fifo0 (
    .reset     (reset),
    .bus_clk   (bus_clk),
    .push      (write_en),
    .push_item (write_data),
    .full      (write_full),
    .pop       (cmd_pop),
    .pop_item  (cmd_item),
    .empty     (cmd_empty)
  );

  msg_decode decode0 (
    .reset      (reset),
    .bus_clk    (bus_clk),
    .fifo_empty (cmd_empty),
    .fifo_item  (cmd_item),
    .fifo_pop   (cmd_pop),
    .cmd        (cmd_if0.producer)
  );

  msg_execute execute0 (
    .reset     (reset),
    .bus_clk   (bus_clk),
    .cmd       (cmd_if0.consumer),
    .rsp       (rsp_if0.producer),
    .msg_count (msg_count),
    .err_count (err_count)
  );

  msg_result result0 (
    .reset     (reset),
    .bus_clk   (bus_clk),
    .rsp       (rsp_if0.consumer),
    .fifo_full (rsp_full),
    .fifo_push (rsp_push),
    .fifo_item (rsp_item)
  );

  msg_fifo #(
    .item_t (resp_word_t),
    .depth  (RSP_DEPTH)
  ) rsp_fifo0 (
    .reset     (reset),
    .bus_clk   (bus_clk),
    .push      (rsp_push),
    .push_item (rsp_item),
    .full      (rsp_full),
    .pop       (read_en),
    .pop_item  (read_data),
    .empty     (read_empty)
  );

endmodule

// ==== hw/msg_result.sv ====
`timescale 1ns/1ps

module msg_result (
  input  logic                         reset,       // clock
  input  logic                         bus_clk,     // async reset, active high
  rsp_if.consumer                      rsp,
  input  logic                         fifo_full,
  output logic                         fifo_push,
  output msg_loopback_pkg::resp_word_t fifo_item
);

  logic ack_q;  // high from push until req drops

  assign rsp.ack = ack_q;

  // one push per item, stalled by a full fifo
  assign fifo_push       = rsp.req && !ack_q && !fifo_full;
  assign fifo_item.seq   = rsp.seq;
  assign fifo_item.value = rsp.value;

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      ack_q <= 1'b0;
    end else if (fifo_push) begin
      ack_q <= 1'b1;
    end else if (ack_q && !rsp.req) begin
      ack_q <= 1'b0;  // four-phase close
    end
  end

  // every ack stands for an item that really entered the fifo
  a_ack_after_push: assert property (
    @(posedge reset) disable iff (bus_clk)
    $rose(rsp.ack) |-> $past(fifo_push && !fifo_full)
  ) else $error("msg_result: ack without a push into free space");

  // a response stalled by a full fifo must stay offered
  a_req_held: assert property (
    @(posedge reset) disable iff (bus_clk)
    (rsp.req && !rsp.ack) |=> rsp.req
  ) else $error("msg_result: req dropped before ack");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the loopback testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_msg_loopback \
  -f build.f \
  -o sim_msg_loopback

./obj_dir/sim_msg_loopback > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished clean"
